/* rtl/busPkg.sv */
// Shared definitions for the AHB-Lite external bus unit
// Bus width, FSM states, AMO opcodes, access sizes and AHB encodings
`default_nettype none

package busPkg;

  // Data and address width, one word per transfer
  localparam int XLEN = 32;

  // HTRANS codes, only single NONSEQ transfers are issued
  localparam logic [1:0] HTRANSIDLE   = 2'b00;
  localparam logic [1:0] HTRANSNONSEQ = 2'b10;

  // Bus FSM states
  // INSTRREADC is an instruction read right behind a data read
  typedef enum logic [2:0] {
    IDLE,
    MEMREAD,
    MEMWRITE,
    INSTRREAD,
    INSTRREADC,
    ATOMICREAD,
    ATOMICWRITE
  } busStateT;

  // AMO opcodes, RISC-V funct5 encoding
  typedef enum logic [4:0] {
    AMOADD  = 5'b00000,
    AMOSWAP = 5'b00001,
    AMOXOR  = 5'b00100,
    AMOOR   = 5'b01000,
    AMOAND  = 5'b01100,
    AMOMIN  = 5'b10000,
    AMOMAX  = 5'b10100,
    AMOMINU = 5'b11000,
    AMOMAXU = 5'b11100
  } amoOpT;

  // Access size, matches the low two bits of HSIZE
  typedef enum logic [1:0] {
    SIZEBYTE = 2'b00,
    SIZEHALF = 2'b01,
    SIZEWORD = 2'b10
  } memSizeT;

endpackage

`default_nettype wire

/* rtl/busAccessIf.sv */
// Data-access control from the bus arbiter to the read-return path
`timescale 1ns/1ps
`default_nettype none

interface busAccessIf
  import busPkg::*;
();

  // Load data on HRDATA is valid this cycle
  logic    captureData;
  // Instruction read sharing the return path with a finished load
  logic    competingRead;

  // Data-phase attributes of the last data access
  logic [1:0] addrLow;
  memSizeT    size;
  logic       unsignedLoad;

  // Arbiter side drives everything
  modport arbiter (
    output captureData,
    output competingRead,
    output addrLow,
    output size,
    output unsignedLoad
  );

  // Read-return side only listens
  modport ret (
    input captureData,
    input competingRead,
    input addrLow,
    input size,
    input unsignedLoad
  );

endinterface

`default_nettype wire

/* rtl/busArbiter.sv */
// Bus arbiter for the AHB-Lite unit
// Data-over-instruction FSM, stall outputs and the AHB address phase
`timescale 1ns/1ps
`default_nettype none

module busArbiter
  import busPkg::*;
(
  input  logic            clk,
  input  logic            reset,
  input  logic            memRead,
  input  logic            memWrite,
  input  logic            atomic,
  input  logic            instrRead,
  input  logic            unsignedLoad,
  input  logic [XLEN-1:0] memAddr,
  input  logic [XLEN-1:0] instrAddr,
  input  memSizeT         memSize,
  input  logic            hready,
  output logic [XLEN-1:0] haddr,
  output logic [2:0]      hsize,
  output logic [1:0]      htrans,
  output logic            hwrite,
  output logic            dataStall,
  output logic            instrStall,
  output logic            grantWrite,
  busAccessIf.arbiter     access
);

  busStateT state;
  busStateT nextState;
  logic     grantData;
  logic     writeNext;

  //////////////////////////////////////////////////////////////////////
  // Bus FSM
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= IDLE;
    end else begin
      state <= nextState;
    end
  end

  // Data wins over instructions in IDLE
  // An instruction read on the bus always finishes first
  always_comb begin
    case (state)
      IDLE: begin
        if (atomic)         nextState = ATOMICREAD;
        else if (memRead)   nextState = MEMREAD;
        else if (memWrite)  nextState = MEMWRITE;
        else if (instrRead) nextState = INSTRREAD;
        else                nextState = IDLE;
      end
      // Read half of the AMO, write half follows directly
      ATOMICREAD: begin
        if (!hready) nextState = ATOMICREAD;
        else         nextState = ATOMICWRITE;
      end
      ATOMICWRITE, MEMWRITE: begin
        if (!hready)        nextState = state;
        else if (instrRead) nextState = INSTRREAD;
        else                nextState = IDLE;
      end
      // Load result still pending on the core side
      MEMREAD: begin
        if (!hready)        nextState = MEMREAD;
        else if (instrRead) nextState = INSTRREADC;
        else                nextState = IDLE;
      end
      INSTRREAD, INSTRREADC: begin
        if (!hready) nextState = state;
        else         nextState = IDLE;
      end
      default: nextState = IDLE;
    endcase
  end

  // Stalls follow the state the bus is heading into
  assign dataStall  = (nextState == MEMREAD) || (nextState == MEMWRITE) ||
                      (nextState == ATOMICREAD) || (nextState == ATOMICWRITE);
  assign instrStall = (nextState == INSTRREAD) || (nextState == INSTRREADC);

  //////////////////////////////////////////////////////////////////////
  // AHB address phase
  //////////////////////////////////////////////////////////////////////

  assign grantData = dataStall;
  assign writeNext = (nextState == MEMWRITE) || (nextState == ATOMICWRITE);

  // Instruction fetches are always full words
  assign haddr  = grantData ? memAddr : instrAddr;
  assign hsize  = grantData ? {1'b0, memSize} : {1'b0, SIZEWORD};
  assign htrans = (nextState != IDLE) ? HTRANSNONSEQ : HTRANSIDLE;
  assign hwrite = writeNext;

  // Write data register loads at the write address phase
  assign grantWrite = writeNext;

  //////////////////////////////////////////////////////////////////////
  // Data-phase attributes and read-return control
  //////////////////////////////////////////////////////////////////////

  // Latched when a data address phase is accepted
  always_ff @(posedge clk) begin
    if (grantData && hready) begin
      access.addrLow      <= memAddr[1:0];
      access.size         <= memSize;
      access.unsignedLoad <= unsignedLoad;
    end
  end

  // HRDATA holds the load value on the last data-phase cycle
  assign access.captureData   = hready && ((state == MEMREAD) || (state == ATOMICREAD));
  assign access.competingRead = (state == INSTRREADC);

endmodule

`default_nettype wire

/* rtl/amoWriteUnit.sv */
// AMO ALU and write-data path of the AHB-Lite unit
// Builds HWDATA one cycle after the write address phase
`timescale 1ns/1ps
`default_nettype none

module amoWriteUnit
  import busPkg::*;
(
  input  logic            clk,
  input  logic            reset,
  input  logic [XLEN-1:0] readData,
  input  logic [XLEN-1:0] writeData,
  input  amoOpT           amoOp,
  input  logic            atomic,
  input  logic            grantWrite,
  output logic [XLEN-1:0] hwdata
);

  logic [XLEN-1:0] amoResult;
  logic [XLEN-1:0] storeData;
  logic            amoPhase;

  // AMO ALU, old memory value against the store operand
  always_comb begin
    case (amoOp)
      AMOADD:  amoResult = readData + writeData;
      AMOSWAP: amoResult = writeData;
      AMOXOR:  amoResult = readData ^ writeData;
      AMOOR:   amoResult = readData | writeData;
      AMOAND:  amoResult = readData & writeData;
      // Signed compares
      AMOMIN:  amoResult = ($signed(readData) < $signed(writeData)) ? readData : writeData;
      AMOMAX:  amoResult = ($signed(readData) > $signed(writeData)) ? readData : writeData;
      // Unsigned compares
      AMOMINU: amoResult = (readData < writeData) ? readData : writeData;
      AMOMAXU: amoResult = (readData > writeData) ? readData : writeData;
      default: amoResult = writeData;
    endcase
  end

  // Store word moves into the data phase with the address
  always_ff @(posedge clk) begin
    if (grantWrite) begin
      storeData <= writeData;
    end
  end

  // Marks the coming data phase as the write half of an AMO
  always_ff @(posedge clk) begin
    if (reset) begin
      amoPhase <= 1'b0;
    end else if (grantWrite) begin
      amoPhase <= atomic;
    end
  end

  // The AMO load value lands on the same edge as the write address phase
  // so its result is formed from readData during the data phase
  // Operands are held by the core until the stall drops
  assign hwdata = amoPhase ? amoResult : storeData;

endmodule

`default_nettype wire

/* rtl/readReturn.sv */
// Load return path of the AHB-Lite unit
// Subword extraction, load capture and the competing-read hold
`timescale 1ns/1ps
`default_nettype none

module readReturn
  import busPkg::*;
(
  input  logic            clk,
  input  logic            reset,
  input  logic [XLEN-1:0] hrdata,
  busAccessIf.ret         access,
  output logic [XLEN-1:0] readData
);

  logic [7:0]      byteSel;
  logic [15:0]     halfSel;
  logic [XLEN-1:0] loadValue;
  logic [XLEN-1:0] newData;
  logic [XLEN-1:0] oldData;

  //////////////////////////////////////////////////////////////////////
  // Subword extraction
  //////////////////////////////////////////////////////////////////////

  // Little-endian lanes picked by the data-phase address
  assign byteSel = hrdata[{access.addrLow, 3'b000} +: 8];
  assign halfSel = hrdata[{access.addrLow[1], 4'b0000} +: 16];

  always_comb begin
    case (access.size)
      SIZEBYTE: begin
        if (access.unsignedLoad) loadValue = {{(XLEN-8){1'b0}}, byteSel};
        else                     loadValue = {{(XLEN-8){byteSel[7]}}, byteSel};
      end
      SIZEHALF: begin
        if (access.unsignedLoad) loadValue = {{(XLEN-16){1'b0}}, halfSel};
        else                     loadValue = {{(XLEN-16){halfSel[15]}}, halfSel};
      end
      default: loadValue = hrdata;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Capture registers
  //////////////////////////////////////////////////////////////////////

  // Newest load result
  always_ff @(posedge clk) begin
    if (reset) begin
      newData <= '0;
    end else if (access.captureData) begin
      newData <= loadValue;
    end
  end

  // Copy of the load result that freezes while an instruction read
  // owns the return path, so the fetch cannot disturb the load value
  always_ff @(posedge clk) begin
    if (reset) begin
      oldData <= '0;
    end else if (!access.competingRead) begin
      oldData <= access.captureData ? loadValue : newData;
    end
  end

  assign readData = access.competingRead ? oldData : newData;

endmodule

`default_nettype wire

/* rtl/ahbLiteBusUnit.sv */
// AHB-Lite external bus unit top
// Joins arbiter, AMO write path and load return to the bus pins
`timescale 1ns/1ps
`default_nettype none

module ahbLiteBusUnit
  import busPkg::*;
(
  input  logic            clk,
  input  logic            reset,
  input  logic            memRead,
  input  logic            memWrite,
  input  logic            atomic,
  input  logic            instrRead,
  input  logic            unsignedLoad,
  input  logic            hready,
  input  logic [XLEN-1:0] memAddr,
  input  logic [XLEN-1:0] instrAddr,
  input  logic [XLEN-1:0] writeData,
  input  logic [XLEN-1:0] hrdata,
  input  memSizeT         memSize,
  input  amoOpT           amoOp,
  output logic [XLEN-1:0] haddr,
  output logic [XLEN-1:0] hwdata,
  output logic [XLEN-1:0] readData,
  output logic [XLEN-1:0] instrRData,
  output logic [2:0]      hsize,
  output logic [1:0]      htrans,
  output logic            hwrite,
  output logic            dataStall,
  output logic            instrStall
);

  logic grantWrite;

  // Data-access control toward the return path
  busAccessIf access ();

  busArbiter uArbiter (
    .clk          (clk),
    .reset        (reset),
    .memRead      (memRead),
    .memWrite     (memWrite),
    .atomic       (atomic),
    .instrRead    (instrRead),
    .unsignedLoad (unsignedLoad),
    .memAddr      (memAddr),
    .instrAddr    (instrAddr),
    .memSize      (memSize),
    .hready       (hready),
    .haddr        (haddr),
    .hsize        (hsize),
    .htrans       (htrans),
    .hwrite       (hwrite),
    .dataStall    (dataStall),
    .instrStall   (instrStall),
    .grantWrite   (grantWrite),
    .access       (access.arbiter)
  );

  amoWriteUnit uAmoWrite (
    .clk        (clk),
    .reset      (reset),
    .readData   (readData),
    .writeData  (writeData),
    .amoOp      (amoOp),
    .atomic     (atomic),
    .grantWrite (grantWrite),
    .hwdata     (hwdata)
  );

  readReturn uReadReturn (
    .clk      (clk),
    .reset    (reset),
    .hrdata   (hrdata),
    .access   (access.ret),
    .readData (readData)
  );

  // Fetch data goes straight from the bus to the core
  assign instrRData = hrdata;

endmodule

`default_nettype wire

/* dv/busChecker.sv */
// Checker for the AHB-Lite bus unit
// Shadow memory, reference models and port comparisons
`timescale 1ns/1ps
`default_nettype none

module busChecker
  import busPkg::*;
(
  input  logic            clk,
  input  logic            reset,
  input  logic            memRead,
  input  logic            memWrite,
  input  logic            atomic,
  input  logic            instrRead,
  input  logic            unsignedLoad,
  input  logic            hready,
  input  logic [XLEN-1:0] memAddr,
  input  logic [XLEN-1:0] instrAddr,
  input  logic [XLEN-1:0] writeData,
  input  memSizeT         memSize,
  input  amoOpT           amoOp,
  input  logic [XLEN-1:0] haddr,
  input  logic [XLEN-1:0] hwdata,
  input  logic [XLEN-1:0] readData,
  input  logic [XLEN-1:0] instrRData,
  input  logic [2:0]      hsize,
  input  logic [1:0]      htrans,
  input  logic            hwrite,
  input  logic            dataStall,
  input  logic            instrStall,
  input  logic [2:0]      testId,
  output int              errorCount,
  output int              checkCount
);

  logic [XLEN-1:0] shadow [64];
  logic [XLEN-1:0] loadExpect;
  logic [XLEN-1:0] lastLoad;
  logic [XLEN-1:0] heldAddr;
  logic [XLEN-1:0] oldWord;
  logic [XLEN-1:0] amoWord;
  logic            prevData;
  logic            prevInstr;
  logic            prevWait;
  logic            sawRequest;
  logic            loadPending;

  //////////////////////////////////////////////////////////////////////
  // Reference models
  //////////////////////////////////////////////////////////////////////

  // Little-endian lane pick plus extension
  function automatic logic [31:0] extractLoad(input logic [31:0] w, input logic [1:0] low,
                                              input memSizeT s, input logic u);
    logic [7:0]  b;
    logic [15:0] h;
    b = 8'(w >> {low, 3'b000});
    h = 16'(w >> {low[1], 4'b0000});
    case (s)
      SIZEBYTE: return u ? {24'd0, b} : {{24{b[7]}}, b};
      SIZEHALF: return u ? {16'd0, h} : {{16{h[15]}}, h};
      default:  return w;
    endcase
  endfunction

  function automatic logic [31:0] amoReference(input logic [31:0] m, input logic [31:0] v,
                                               input amoOpT op);
    case (op)
      AMOADD:  return m + v;
      AMOXOR:  return m ^ v;
      AMOOR:   return m | v;
      AMOAND:  return m & v;
      AMOMIN:  return ($signed(m) < $signed(v)) ? m : v;
      AMOMAX:  return ($signed(m) > $signed(v)) ? m : v;
      AMOMINU: return (m < v) ? m : v;
      AMOMAXU: return (m > v) ? m : v;
      default: return v;
    endcase
  endfunction

  function automatic string testName(input logic [2:0] id);
    case (id)
      3'd0:    return "resetState";
      3'd1:    return "wordStoreLoad";
      3'd2:    return "subwordLoad";
      3'd3:    return "amoOps";
      3'd4:    return "loadWithFetch";
      default: return "randomWaits";
    endcase
  endfunction

  task automatic compareValue(input logic [31:0] expected, input logic [31:0] actual);
    checkCount = checkCount + 1;
    if (expected !== actual) begin
      errorCount = errorCount + 1;
      $display("ERROR %s expected %h actual %h at %0t",
               testName(testId), expected, actual, $time);
    end
  endtask

  initial begin
    errorCount = 0;
    checkCount = 0;
    // Same fill pattern as the memory model
    for (int i = 0; i < 64; i++) begin
      shadow[i] = (32'h9E37_79B9 * (32'(i) + 32'd1)) ^ (32'(i) << 24);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Monitor, sampled mid-cycle
  //////////////////////////////////////////////////////////////////////

  always @(negedge clk) begin
    if (reset) begin
      prevData    = 1'b0;
      prevInstr   = 1'b0;
      prevWait    = 1'b0;
      sawRequest  = 1'b0;
      loadPending = 1'b0;
      lastLoad    = '0;
    end else begin
      // Quiet bus until the first request
      if (!sawRequest && !(memRead || memWrite || atomic || instrRead)) begin
        compareValue(32'd0, {27'd0, htrans, hwrite, dataStall, instrStall});
      end
      if (memRead || memWrite || atomic || instrRead) sawRequest = 1'b1;
      // Address phase must hold while the bus keeps waiting
      if (prevWait && !hready) compareValue(heldAddr, haddr);
      // A data request opens with its own address and size
      if (!prevData && dataStall) begin
        compareValue(memAddr, haddr);
        compareValue({30'd0, memSize}, {29'd0, hsize});
      end
      // Fetches always go out as words
      if (!prevInstr && instrStall) begin
        compareValue(instrAddr, haddr);
        compareValue({30'd0, SIZEWORD}, {29'd0, hsize});
      end
      // readData is registered one cycle behind the stall
      if (loadPending) begin
        compareValue(loadExpect, readData);
        loadPending = 1'b0;
      end
      if (prevData && !dataStall) begin
        oldWord = shadow[memAddr[7:2]];
        if (atomic) begin
          amoWord = amoReference(oldWord, writeData, amoOp);
          compareValue(amoWord, hwdata);
          shadow[memAddr[7:2]] = amoWord;
          loadExpect  = oldWord;
          lastLoad    = oldWord;
          loadPending = 1'b1;
        end else if (memRead) begin
          loadExpect  = extractLoad(oldWord, memAddr[1:0], memSize, unsignedLoad);
          lastLoad    = loadExpect;
          loadPending = 1'b1;
        end else if (memWrite) begin
          compareValue(writeData, hwdata);
          shadow[memAddr[7:2]] = writeData;
        end
        // A waiting fetch takes the next address phase
        if (instrRead) begin
          compareValue(32'd1, {31'd0, instrStall});
          compareValue(instrAddr, haddr);
        end
      end
      if (prevInstr && !instrStall) begin
        compareValue(shadow[instrAddr[7:2]], instrRData);
        compareValue(lastLoad, readData);
      end
      prevData  = dataStall;
      prevInstr = instrStall;
      prevWait  = !hready && (htrans == HTRANSNONSEQ);
      heldAddr  = haddr;
    end
  end

endmodule

`default_nettype wire

/* dv/tbAhbLiteBusUnit.sv */
// Testbench for the AHB-Lite bus unit
// Clock, AHB memory model with wait states, stimulus and watchdog
`timescale 1ns/1ps
`default_nettype none

module tbAhbLiteBusUnit
  import busPkg::*;
();

  localparam int NUMTESTS  = 250;
  localparam int CLKPERIOD = 40;

  logic            clk;
  logic            reset;
  logic            memRead;
  logic            memWrite;
  logic            atomic;
  logic            instrRead;
  logic            unsignedLoad;
  logic            hready;
  logic [XLEN-1:0] memAddr;
  logic [XLEN-1:0] instrAddr;
  logic [XLEN-1:0] writeData;
  logic [XLEN-1:0] hrdata;
  memSizeT         memSize;
  amoOpT           amoOp;
  logic [XLEN-1:0] haddr;
  logic [XLEN-1:0] hwdata;
  logic [XLEN-1:0] readData;
  logic [XLEN-1:0] instrRData;
  logic [2:0]      hsize;
  logic [1:0]      htrans;
  logic            hwrite;
  logic            dataStall;
  logic            instrStall;

  int              errorCount;
  int              checkCount;
  logic [2:0]      testId;
  logic [31:0]     stimState;
  logic [31:0]     waitState;
  logic            waitEnable;

  // Memory model state
  logic [XLEN-1:0] mem [64];
  logic            pendValid;
  logic            pendWrite;
  logic [5:0]      pendAddr;

  ahbLiteBusUnit uut (
    .clk(clk), .reset(reset), .memRead(memRead), .memWrite(memWrite),
    .atomic(atomic), .instrRead(instrRead), .unsignedLoad(unsignedLoad),
    .hready(hready), .memAddr(memAddr), .instrAddr(instrAddr),
    .writeData(writeData), .hrdata(hrdata), .memSize(memSize), .amoOp(amoOp),
    .haddr(haddr), .hwdata(hwdata), .readData(readData), .instrRData(instrRData),
    .hsize(hsize), .htrans(htrans), .hwrite(hwrite), .dataStall(dataStall),
    .instrStall(instrStall)
  );

  busChecker chk (
    .clk(clk), .reset(reset), .memRead(memRead), .memWrite(memWrite),
    .atomic(atomic), .instrRead(instrRead), .unsignedLoad(unsignedLoad),
    .hready(hready), .memAddr(memAddr), .instrAddr(instrAddr),
    .writeData(writeData), .memSize(memSize), .amoOp(amoOp), .haddr(haddr),
    .hwdata(hwdata), .readData(readData), .instrRData(instrRData),
    .hsize(hsize), .htrans(htrans), .hwrite(hwrite), .dataStall(dataStall),
    .instrStall(instrStall), .testId(testId), .errorCount(errorCount),
    .checkCount(checkCount)
  );

  always #(CLKPERIOD/2) clk = ~clk;

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Keeps the address inside the 64-word model, aligned to the size
  function automatic logic [31:0] alignedAddr(input logic [31:0] r, input memSizeT s);
    logic [31:0] a;
    a = {24'd0, r[7:0]};
    if (s == SIZEHALF) a[0] = 1'b0;
    if (s == SIZEWORD) a[1:0] = 2'b00;
    return a;
  endfunction

  function automatic amoOpT amoFromIndex(input logic [31:0] v);
    case (v % 32'd9)
      32'd0:   return AMOADD;
      32'd1:   return AMOSWAP;
      32'd2:   return AMOXOR;
      32'd3:   return AMOOR;
      32'd4:   return AMOAND;
      32'd5:   return AMOMIN;
      32'd6:   return AMOMAX;
      32'd7:   return AMOMINU;
      default: return AMOMAXU;
    endcase
  endfunction

  //////////////////////////////////////////////////////////////////////
  // AHB memory model
  //////////////////////////////////////////////////////////////////////

  // Wait states only stretch a data phase that is pending
  always @(posedge clk) begin
    waitState = xorshift(waitState);
    if (reset) begin
      hready    <= 1'b1;
      pendValid <= 1'b0;
      pendWrite <= 1'b0;
      hrdata    <= '0;
    end else if (hready) begin
      if (pendValid && pendWrite) mem[pendAddr] <= hwdata;
      if (htrans == HTRANSNONSEQ) begin
        pendValid <= 1'b1;
        pendWrite <= hwrite;
        pendAddr  <= haddr[7:2];
        // Forward a write finishing on the same word
        if (pendValid && pendWrite && pendAddr == haddr[7:2]) hrdata <= hwdata;
        else hrdata <= mem[haddr[7:2]];
        hready <= !waitEnable || (waitState[1:0] != 2'b00);
      end else begin
        pendValid <= 1'b0;
      end
    end else begin
      hready <= !waitEnable || (waitState[1:0] != 2'b00);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus tasks
  //////////////////////////////////////////////////////////////////////

  task automatic waitDataDone();
    do @(negedge clk); while (dataStall);
  endtask

  task automatic waitInstrDone();
    do @(negedge clk); while (instrStall);
  endtask

  task automatic runLoad(input logic [31:0] a, input memSizeT s, input logic u);
    @(posedge clk);
    memRead      <= 1'b1;
    memAddr      <= a;
    memSize      <= s;
    unsignedLoad <= u;
    waitDataDone();
    @(posedge clk);
    memRead <= 1'b0;
  endtask

  task automatic runStore(input logic [31:0] a, input logic [31:0] d);
    @(posedge clk);
    memWrite  <= 1'b1;
    memAddr   <= a;
    memSize   <= SIZEWORD;
    writeData <= d;
    waitDataDone();
    @(posedge clk);
    memWrite <= 1'b0;
  endtask

  task automatic runAmo(input logic [31:0] a, input logic [31:0] d, input amoOpT op);
    @(posedge clk);
    atomic    <= 1'b1;
    memAddr   <= a;
    memSize   <= SIZEWORD;
    writeData <= d;
    amoOp     <= op;
    waitDataDone();
    @(posedge clk);
    atomic <= 1'b0;
  endtask

  task automatic runFetch(input logic [31:0] a);
    @(posedge clk);
    instrRead <= 1'b1;
    instrAddr <= a;
    waitInstrDone();
    @(posedge clk);
    instrRead <= 1'b0;
  endtask

  // Load and fetch raised together, load goes first
  task automatic runLoadFetch(input logic [31:0] a, input memSizeT s, input logic u,
                              input logic [31:0] ia);
    @(posedge clk);
    memRead      <= 1'b1;
    instrRead    <= 1'b1;
    memAddr      <= a;
    memSize      <= s;
    unsignedLoad <= u;
    instrAddr    <= ia;
    waitDataDone();
    @(posedge clk);
    memRead <= 1'b0;
    waitInstrDone();
    @(posedge clk);
    instrRead <= 1'b0;
  endtask

  task automatic nextRandom(output logic [31:0] r);
    stimState = xorshift(stimState);
    r = stimState;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    logic [31:0] r;
    logic [31:0] r2;
    memSizeT     s;
    clk          = 1'b0;
    reset        = 1'b1;
    memRead      = 1'b0;
    memWrite     = 1'b0;
    atomic       = 1'b0;
    instrRead    = 1'b0;
    unsignedLoad = 1'b0;
    hready       = 1'b1;
    hrdata       = '0;
    memAddr      = '0;
    instrAddr    = '0;
    writeData    = '0;
    memSize      = SIZEWORD;
    amoOp        = AMOADD;
    testId       = 3'd0;
    waitEnable   = 1'b0;
    stimState    = 32'd57914;
    waitState    = xorshift(32'd57914 ^ 32'hA5A5_5A5A);
    // Fill pattern mixes every address bit
    for (int i = 0; i < 64; i++) begin
      mem[i] = (32'h9E37_79B9 * (32'(i) + 32'd1)) ^ (32'(i) << 24);
    end
    repeat (8) @(posedge clk);
    reset <= 1'b0;
    repeat (3) @(posedge clk);

    // Word store then load
    testId <= 3'd1;
    runStore(32'h10, 32'hDEAD_BEEF);
    runLoad(32'h10, SIZEWORD, 1'b0);
    runStore(32'hFC, 32'h1234_5678);
    runLoad(32'hFC, SIZEWORD, 1'b1);

    // Every subword lane, both signs
    testId <= 3'd2;
    runStore(32'h20, 32'h80FF_7F01);
    for (int k = 0; k < 4; k++) begin
      runLoad(32'h20 + 32'(k), SIZEBYTE, 1'b0);
      runLoad(32'h20 + 32'(k), SIZEBYTE, 1'b1);
    end
    for (int k = 0; k < 4; k += 2) begin
      runLoad(32'h20 + 32'(k), SIZEHALF, 1'b0);
      runLoad(32'h20 + 32'(k), SIZEHALF, 1'b1);
    end
    runLoad(32'h20, SIZEWORD, 1'b0);

    // Each AMO, followed by a load of the result
    testId <= 3'd3;
    for (int k = 0; k < 9; k++) begin
      nextRandom(r);
      nextRandom(r2);
      runStore(32'h40, r);
      runAmo(32'h40, r2, amoFromIndex(32'(k)));
      runLoad(32'h40, SIZEWORD, 1'b0);
    end

    // Load and fetch together
    testId <= 3'd4;
    runLoadFetch(32'h21, SIZEBYTE, 1'b0, 32'h80);
    runLoadFetch(32'h22, SIZEHALF, 1'b1, 32'h84);
    runLoadFetch(32'h40, SIZEWORD, 1'b0, 32'h40);
    runFetch(32'hF0);

    // Mixed requests with wait states
    testId     <= 3'd5;
    waitEnable <= 1'b1;
    for (int n = 0; n < 200; n++) begin
      nextRandom(r);
      nextRandom(r2);
      s = (r[9:8] == 2'b11) ? SIZEWORD : memSizeT'(r[9:8]);
      case (r[14:12] % 3'd5)
        3'd0:    runLoad(alignedAddr(r, s), s, r[16]);
        3'd1:    runStore(alignedAddr(r, SIZEWORD), r2);
        3'd2:    runAmo(alignedAddr(r, SIZEWORD), r2, amoFromIndex(r2 >> 7));
        3'd3:    runFetch(alignedAddr(r2, SIZEWORD));
        default: runLoadFetch(alignedAddr(r, s), s, r[16], alignedAddr(r2, SIZEWORD));
      endcase
    end

    repeat (4) @(posedge clk);
    $display("Errors: %0d of %0d checks", errorCount, checkCount);
    if (errorCount == 0 && checkCount > 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  // Watchdog, 20 cycles per test
  initial begin
    #(NUMTESTS * 20 * CLKPERIOD);
    $display("Timeout: the tests did not finish in time");
    $display("CHECKS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* ahbLiteBus.f */
rtl/busPkg.sv
rtl/busAccessIf.sv
rtl/busArbiter.sv
rtl/amoWriteUnit.sv
rtl/readReturn.sv
rtl/ahbLiteBusUnit.sv
dv/busChecker.sv
dv/tbAhbLiteBusUnit.sv

/* runSim.sh */
#!/bin/sh
# Build and run the bus unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tbAhbLiteBusUnit -f ahbLiteBus.f -o simTb
./obj_dir/simTb > sim.log 2>&1
cat sim.log

if grep -q "CHECKS FAILED" sim.log; then
  echo "Simulation failed"
  exit 1
fi
echo "Simulation passed"
